//--- logic/interp_config.svh
`ifndef INTERP_CONFIG_SVH
`define INTERP_CONFIG_SVH

// sample width of each rail
`define INTERP_DW 18

// symbol buffer depth, level port is 4 bits
`define INTERP_FIFO_DEPTH 8

// sys_clk cycles per output-rate strobe
`define INTERP_TW_DIV 4

// ------------------------------
// low-pass reset coefficients
// ------------------------------
`define INTERP_COEF0_DEF (-18'sd2820)
`define INTERP_COEF1_DEF (18'sd0)
`define INTERP_COEF2_DEF (18'sd24575)
`define INTERP_COEF3_DEF (18'sd43513)

// ------------------------------
// apb byte offsets
// ------------------------------
`define INTERP_ADDR_CTRL   8'h00
`define INTERP_ADDR_COEF0  8'h04
`define INTERP_ADDR_COEF1  8'h08
`define INTERP_ADDR_COEF2  8'h0c
`define INTERP_ADDR_COEF3  8'h10
`define INTERP_ADDR_STATUS 8'h14

`endif

//--- logic/interp_pkg.sv
`include "interp_config.svh"

package interp_pkg;

	// ------------------------------
	// datapath payloads
	// ------------------------------

	// one i/q symbol or output sample, i in the upper half
	typedef struct packed {
		logic signed [`INTERP_DW-1:0] i;
		logic signed [`INTERP_DW-1:0] q;
	} iq_sample_t;

	// unique taps of the symmetric fir
	// c0 outer pair, c3 center tap
	typedef struct packed {
		logic signed [17:0] c0;
		logic signed [17:0] c1;
		logic signed [17:0] c2;
		logic signed [17:0] c3;
	} coef_set_t;

	// ------------------------------
	// timing and control
	// ------------------------------

	// sym_en only ever high together with tw_en
	typedef struct packed {
		logic tw_en;
		logic sym_en;
	} rate_strobe_t;

	typedef struct packed {
		logic run;
		logic clear_underflow;
	} interp_ctrl_t;

	// read-only view in the STATUS register
	typedef struct packed {
		logic [15:0] underflow_count;
		logic [3:0]  fifo_level;
	} interp_status_t;

endpackage

//--- logic/clk_en_gen.sv
`timescale 1ns/1ps
`include "interp_config.svh"

module clk_en_gen (
	input  logic                      sys_clk,
	input  logic                      reset,
	input  logic                      run,
	output interp_pkg::rate_strobe_t  strobe
);

	localparam int CW = (`INTERP_TW_DIV > 1) ? $clog2(`INTERP_TW_DIV) : 1;

	logic [CW-1:0] div_cnt;
	logic          phase;
	logic          wrap;

	// last cycle of the divider period
	assign wrap = (div_cnt == CW'(`INTERP_TW_DIV - 1));

	// ------------------------------
	// divider and symbol phase
	// ------------------------------
	always_ff @(posedge sys_clk)
	begin
		if (reset || !run)
		begin
			// restart from a clean period when halted
			div_cnt <= '0;
			phase   <= 1'b0;
			strobe  <= '0;
		end
		else
		begin
			strobe.tw_en  <= wrap;
			// first strobe after run carries the symbol
			strobe.sym_en <= wrap && !phase;
			if (wrap)
			begin
				div_cnt <= '0;
				phase   <= ~phase;
			end
			else
			begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// symbol strobe is a subset of the output-rate strobe
	a_sym_in_tw: assert property (
		@(posedge sys_clk) disable iff (reset)
		strobe.sym_en |-> strobe.tw_en
	);

endmodule

//--- logic/symbol_fifo.sv
`timescale 1ns/1ps
`include "interp_config.svh"

module symbol_fifo (
	input  logic                     sys_clk,
	input  logic                     reset,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  interp_pkg::iq_sample_t   in_data,
	input  logic                     pop,
	output interp_pkg::iq_sample_t   head,
	output logic                     empty,
	output logic [3:0]               level
);

	localparam int DEPTH = `INTERP_FIFO_DEPTH;
	localparam int AW    = $clog2(DEPTH);

	interp_pkg::iq_sample_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [3:0]    count;
	logic          push;
	logic          pull;

	// ------------------------------
	// handshake
	// ------------------------------
	assign in_ready = (count != 4'(DEPTH));
	assign empty    = (count == 4'd0);
	assign level    = count;
	assign push     = in_valid && in_ready;
	// popping an empty buffer just yields the zero head
	assign pull     = pop && !empty;

	// zero symbol on underflow
	assign head = empty ? '0 : mem[rd_ptr];

	// storage, no reset on payload
	always_ff @(posedge sys_clk)
	begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	// ------------------------------
	// pointers and count
	// ------------------------------
	always_ff @(posedge sys_clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= 4'd0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pull)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pull keep the level
			if (push && !pull)
				count <= count + 4'd1;
			else if (pull && !push)
				count <= count - 4'd1;
		end
	end

	a_level_max: assert property (
		@(posedge sys_clk) disable iff (reset)
		level <= 4'(DEPTH)
	);

endmodule

//--- logic/upsample_fir.sv
`timescale 1ns/1ps
`include "interp_config.svh"

module upsample_fir (
	input  logic                          sys_clk,
	input  logic                          reset,
	input  interp_pkg::rate_strobe_t      strobe,
	input  logic signed [`INTERP_DW-1:0]  x_in,
	input  interp_pkg::coef_set_t         coefs,
	output logic signed [`INTERP_DW-1:0]  y
);

	localparam int DW   = `INTERP_DW;
	localparam int NTAP = 7;

	// zero-stuffed input at output rate
	logic signed [DW-1:0]   x_up;
	// delay line, tap 0 newest
	logic signed [DW-1:0]   x [NTAP];
	// symmetric pre-adds, index 3 is the center tap
	logic signed [DW-1:0]   pre [4];
	logic signed [17:0]     coef [4];
	logic signed [2*DW-1:0] prod [4];
	logic signed [DW-1:0]   term [4];
	logic signed [DW-1:0]   sum_a;
	logic signed [DW-1:0]   sum_b;
	logic signed [DW-1:0]   sum_all;

	// ------------------------------
	// zero stuffing
	// ------------------------------

	// symbol on sym_en, zero on the odd strobe
	always_ff @(posedge sys_clk)
	begin
		if (reset)
			x_up <= '0;
		else if (strobe.tw_en)
			x_up <= strobe.sym_en ? x_in : '0;
	end

	// ------------------------------
	// delay line
	// ------------------------------
	always_ff @(posedge sys_clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < NTAP; k++)
				x[k] <= '0;
		end
		else if (strobe.tw_en)
		begin
			// halve on entry, arithmetic shift keeps the sign
			x[0] <= x_up >>> 1;
			for (int k = 1; k < NTAP; k++)
				x[k] <= x[k-1];
		end
	end

	// ------------------------------
	// pre-adds
	// ------------------------------

	// pairs (0,6) (1,5) (2,4) share a coefficient
	always_ff @(posedge sys_clk)
	begin
		if (reset)
		begin
			for (int k = 0; k < 4; k++)
				pre[k] <= '0;
		end
		else if (strobe.tw_en)
		begin
			for (int k = 0; k < 3; k++)
				pre[k] <= x[k] + x[NTAP-1-k];
			pre[3] <= x[3];
		end
	end

	// ------------------------------
	// multiply and sum
	// ------------------------------

	// unpack the coefficient set
	always_comb
	begin
		coef[0] = coefs.c0;
		coef[1] = coefs.c1;
		coef[2] = coefs.c2;
		coef[3] = coefs.c3;
	end

	// full precision product, keep bits 33:16
	always_comb
	begin
		for (int k = 0; k < 4; k++)
		begin
			prod[k] = pre[k] * coef[k];
			term[k] = prod[k][33:16];
		end
	end

	// adder tree, 18-bit wraparound
	assign sum_a   = term[0] + term[1];
	assign sum_b   = term[2] + term[3];
	assign sum_all = sum_a + sum_b;

	// output register
	always_ff @(posedge sys_clk)
	begin
		if (reset)
			y <= '0;
		else if (strobe.tw_en)
			y <= sum_all;
	end

	// output only moves on the edge that follows a strobe
	a_y_stable: assert property (
		@(posedge sys_clk) disable iff (reset)
		!$past(strobe.tw_en) |-> $stable(y)
	);

endmodule

//--- logic/interp_apb_regs.sv
`timescale 1ns/1ps
`include "interp_config.svh"

module interp_apb_regs (
	input  logic                        sys_clk,
	input  logic                        reset,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [7:0]                  paddr,
	input  logic [31:0]                 pwdata,
	output logic [31:0]                 prdata,
	output logic                        pready,
	output logic                        pslverr,
	output interp_pkg::interp_ctrl_t    ctrl,
	output interp_pkg::coef_set_t       coefs,
	input  logic                        underflow,
	input  logic [3:0]                  fifo_level
);

	interp_pkg::interp_status_t status;

	logic        setup_ph;
	logic        wr_en;
	logic        addr_ok;
	logic [31:0] rd_mux;
	logic [15:0] uf_count;

	// zero wait states
	assign pready   = 1'b1;
	assign setup_ph = psel && !penable;
	assign wr_en    = psel && penable && pwrite;

	assign status.underflow_count = uf_count;
	assign status.fifo_level      = fifo_level;

	// ------------------------------
	// address decode and read mux
	// ------------------------------
	always_comb
	begin
		addr_ok = 1'b1;
		rd_mux  = '0;
		case (paddr)
			`INTERP_ADDR_CTRL:   rd_mux = {31'd0, ctrl.run};
			// coefficients read back sign extended
			`INTERP_ADDR_COEF0:  rd_mux = 32'(coefs.c0);
			`INTERP_ADDR_COEF1:  rd_mux = 32'(coefs.c1);
			`INTERP_ADDR_COEF2:  rd_mux = 32'(coefs.c2);
			`INTERP_ADDR_COEF3:  rd_mux = 32'(coefs.c3);
			`INTERP_ADDR_STATUS: rd_mux = {12'd0, status.fifo_level, status.underflow_count};
			default:             addr_ok = 1'b0;
		endcase
	end

	// read data and error captured in setup, presented in access
	always_ff @(posedge sys_clk)
	begin
		if (reset)
		begin
			prdata  <= '0;
			pslverr <= 1'b0;
		end
		else
		begin
			if (setup_ph && !pwrite)
				prdata <= rd_mux;
			pslverr <= setup_ph &&
				(!addr_ok || (pwrite && paddr == `INTERP_ADDR_STATUS));
		end
	end

	// ------------------------------
	// control and coefficients
	// ------------------------------
	always_ff @(posedge sys_clk)
	begin
		if (reset)
		begin
			ctrl     <= '0;
			coefs.c0 <= `INTERP_COEF0_DEF;
			coefs.c1 <= `INTERP_COEF1_DEF;
			coefs.c2 <= `INTERP_COEF2_DEF;
			coefs.c3 <= `INTERP_COEF3_DEF;
		end
		else
		begin
			// clear bit is a one cycle pulse
			ctrl.clear_underflow <= wr_en && (paddr == `INTERP_ADDR_CTRL) && pwdata[1];
			if (wr_en)
			begin
				case (paddr)
					`INTERP_ADDR_CTRL:  ctrl.run <= pwdata[0];
					`INTERP_ADDR_COEF0: coefs.c0 <= pwdata[17:0];
					`INTERP_ADDR_COEF1: coefs.c1 <= pwdata[17:0];
					`INTERP_ADDR_COEF2: coefs.c2 <= pwdata[17:0];
					`INTERP_ADDR_COEF3: coefs.c3 <= pwdata[17:0];
					default: ;
				endcase
			end
		end
	end

	// saturating underflow count
	always_ff @(posedge sys_clk)
	begin
		if (reset || ctrl.clear_underflow)
			uf_count <= '0;
		else if (underflow && uf_count != 16'hffff)
			uf_count <= uf_count + 16'd1;
	end

	a_penable_psel: assert property (
		@(posedge sys_clk) disable iff (reset)
		penable |-> psel
	);

endmodule

//--- logic/interp_top.sv
`timescale 1ns/1ps

module interp_top (
	input  logic                    sys_clk,
	input  logic                    reset,
	// apb slave
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [7:0]              paddr,
	input  logic [31:0]             pwdata,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	// symbol input
	input  logic                    in_valid,
	output logic                    in_ready,
	input  interp_pkg::iq_sample_t  in_data,
	// 2x rate output, no back-pressure
	output logic                    out_valid,
	output interp_pkg::iq_sample_t  out_data
);

	interp_pkg::interp_ctrl_t ctrl;
	interp_pkg::coef_set_t    coefs;
	interp_pkg::rate_strobe_t strobe;
	interp_pkg::iq_sample_t   head;

	logic                fifo_empty;
	logic [3:0]          fifo_level;
	logic                underflow;
	logic signed [17:0]  y_i;
	logic signed [17:0]  y_q;

	// zero symbol sent when nothing is buffered
	assign underflow = strobe.sym_en && fifo_empty;

	// ------------------------------
	// control path
	// ------------------------------
	interp_apb_regs i_regs (
		.sys_clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .ctrl, .coefs, .underflow, .fifo_level
	);

	clk_en_gen i_clk_en (.sys_clk, .reset, .run(ctrl.run), .strobe);

	// ------------------------------
	// datapath
	// ------------------------------
	symbol_fifo i_fifo (
		.sys_clk, .reset, .in_valid, .in_ready, .in_data,
		.pop(strobe.sym_en), .head, .empty(fifo_empty), .level(fifo_level)
	);

	upsample_fir i_fir_i (.sys_clk, .reset, .strobe, .x_in(head.i), .coefs, .y(y_i));
	upsample_fir i_fir_q (.sys_clk, .reset, .strobe, .x_in(head.q), .coefs, .y(y_q));

	// fir outputs settle on the strobe edge
	always_ff @(posedge sys_clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= strobe.tw_en;
	end

	assign out_data = interp_pkg::iq_sample_t'{i: y_i, q: y_q};

endmodule

//--- tb/interp_tb.sv
`timescale 1ns/1ps
`include "interp_config.svh"

module interp_tb;

	logic                   sys_clk = 1'b0;
	logic                   reset;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [7:0]             paddr;
	logic [31:0]            pwdata;
	logic [31:0]            prdata;
	logic                   pready;
	logic                   pslverr;
	logic                   in_valid;
	logic                   in_ready;
	interp_pkg::iq_sample_t in_data;
	logic                   out_valid;
	interp_pkg::iq_sample_t out_data;

	int checks;
	int errors;
	int test_err;
	int test_num;
	int out_count;
	int uf_model;
	int gap;
	bit sym_next;
	bit pend_v;
	interp_pkg::iq_sample_t pend_d;
	// symbols accepted by the dut in order
	interp_pkg::iq_sample_t sym_q[$];
	// halved stuffed samples with index 0 newest
	int hist_i[9];
	int hist_q[9];
	int coef_m[4];
	int defs[4] = '{`INTERP_COEF0_DEF, `INTERP_COEF1_DEF, `INTERP_COEF2_DEF, `INTERP_COEF3_DEF};

	always #5 sys_clk = ~sys_clk;

	interp_top i_dut (.*);

	// ------------------------------
	// checking and reference model
	// ------------------------------
	task automatic check_value(input string name, input int exp, input int act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	function automatic int wrap18(input int v);
		logic signed [17:0] t;
		t = v[17:0];
		return int'(t);
	endfunction

	// y(n) sees the stuffed stream three strobes back so taps are h[2..8]
	function automatic int ref_fir(input int h[9], input int c[4]);
		int          pre[4];
		longint      prod;
		logic [63:0] pbits;
		logic signed [17:0] term;
		int          acc;
		pre[0] = wrap18(h[2] + h[8]);
		pre[1] = wrap18(h[3] + h[7]);
		pre[2] = wrap18(h[4] + h[6]);
		pre[3] = h[5];
		acc = 0;
		for (int k = 0; k < 4; k++)
		begin
			prod  = longint'(pre[k]) * longint'(c[k]);
			pbits = prod;
			term  = pbits[33:16];
			acc   = acc + int'(term);
		end
		return wrap18(acc);
	endfunction

	// per output strobe pop on the symbol phase then compare and shift history
	task score_output();
		interp_pkg::iq_sample_t d;
		d = '0;
		if (sym_next)
		begin
			if (sym_q.size() > 0)
				d = sym_q.pop_front();
			else
				uf_model++;
		end
		check_value("out_data.i", ref_fir(hist_i, coef_m), int'(out_data.i));
		check_value("out_data.q", ref_fir(hist_q, coef_m), int'(out_data.q));
		for (int k = 8; k > 0; k--)
		begin
			hist_i[k] = hist_i[k-1];
			hist_q[k] = hist_q[k-1];
		end
		hist_i[0] = int'(d.i) >>> 1;
		hist_q[0] = int'(d.q) >>> 1;
		sym_next = !sym_next;
		out_count++;
	endtask

	always @(posedge sys_clk)
	begin
		if (reset)
		begin
			gap    = 100;
			pend_v = 1'b0;
			for (int k = 0; k < 9; k++)
			begin
				hist_i[k] = 0;
				hist_q[k] = 0;
			end
		end
		else
		begin
			if (out_valid)
			begin
				// long silence means run restarted and the first strobe carries a symbol
				if (gap > `INTERP_TW_DIV)
					sym_next = 1'b1;
				gap = 0;
				score_output();
			end
			else
				gap++;
			// a push is visible to the pop one edge later
			if (pend_v)
				sym_q.push_back(pend_d);
			pend_v = in_valid && in_ready;
			pend_d = in_data;
		end
	end

	// ------------------------------
	// bus and stream tasks
	// ------------------------------
	task automatic apb_access(input bit wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge sys_clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge sys_clk);
		penable <= 1'b1;
		// access phase ends here with zero wait states
		@(posedge sys_clk);
		rdata = prdata;
		err   = pslverr;
		check_value("pready", 1, int'(pready));
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input int data);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, addr, data, rd, err);
		check_value("pslverr", 0, int'(err));
		if (addr >= `INTERP_ADDR_COEF0 && addr <= `INTERP_ADDR_COEF3)
			coef_m[(addr - `INTERP_ADDR_COEF0) >> 2] = wrap18(data);
	endtask

	task automatic reg_read(input logic [7:0] addr, output logic [31:0] rd);
		logic err;
		apb_access(1'b0, addr, 32'd0, rd, err);
		check_value("pslverr", 0, int'(err));
	endtask

	// source holds the symbol until in_ready
	task automatic push_symbol(input int i_val, input int q_val);
		int t;
		@(posedge sys_clk);
		in_valid  <= 1'b1;
		in_data.i <= i_val[17:0];
		in_data.q <= q_val[17:0];
		t = 0;
		do
		begin
			@(posedge sys_clk);
			t++;
			if (t > 400)
				timeout_fail("in_ready");
		end
		while (!in_ready);
		in_valid <= 1'b0;
	endtask

	task automatic wait_outputs(input int n);
		int target;
		int t;
		target = out_count + n;
		t = 0;
		while (out_count < target)
		begin
			@(posedge sys_clk);
			t++;
			if (t > 100 * `INTERP_TW_DIV * n)
				timeout_fail("output samples");
		end
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		do
		begin
			@(posedge sys_clk);
			t++;
			if (t > 5000)
				timeout_fail("the symbol FIFO to drain");
		end
		while (sym_q.size() > 0 || pend_v);
	endtask

	// stop and expect no out_valid once the divider period is over
	task automatic halt_run();
		bit seen;
		reg_write(`INTERP_ADDR_CTRL, 0);
		repeat (`INTERP_TW_DIV) @(posedge sys_clk);
		seen = 1'b0;
		repeat (4 * `INTERP_TW_DIV)
		begin
			@(posedge sys_clk);
			seen = seen | out_valid;
		end
		check_value("out_valid", 0, int'(seen));
	endtask

	task automatic end_test(input string name);
		test_num++;
		$display("test %0d %s: %s", test_num, name, (errors == test_err) ? "ok" : "mismatch");
		test_err = errors;
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial
	begin
		logic [31:0] rd;
		logic        err;
		int          v;
		void'($urandom(74));
		reset    <= 1'b1;
		psel     <= 1'b0;
		penable  <= 1'b0;
		pwrite   <= 1'b0;
		paddr    <= 8'd0;
		pwdata   <= 32'd0;
		in_valid <= 1'b0;
		in_data  <= '0;
		checks    = 0;
		errors    = 0;
		test_err  = 0;
		test_num  = 0;
		out_count = 0;
		uf_model  = 0;
		coef_m    = defs;
		repeat (4) @(posedge sys_clk);
		reset <= 1'b0;
		@(posedge sys_clk);

		// defaults, readback, unmapped offset
		reg_read(`INTERP_ADDR_CTRL, rd);
		check_value("ctrl", 0, int'(rd));
		for (int k = 0; k < 4; k++)
		begin
			reg_read(8'(`INTERP_ADDR_COEF0 + 4 * k), rd);
			check_value("coef default", defs[k], int'(rd));
			v = wrap18($urandom);
			reg_write(8'(`INTERP_ADDR_COEF0 + 4 * k), v);
			reg_read(8'(`INTERP_ADDR_COEF0 + 4 * k), rd);
			check_value("coef readback", v, int'(rd));
			reg_write(8'(`INTERP_ADDR_COEF0 + 4 * k), defs[k]);
		end
		apb_access(1'b0, 8'h18, 32'd0, rd, err);
		check_value("pslverr on 0x18", 1, int'(err));
		end_test("register access");

		// single symbol through the default filter
		push_symbol(65536, -65536);
		reg_write(`INTERP_ADDR_CTRL, 1);
		wait_outputs(16);
		halt_run();
		end_test("impulse");

		reg_write(`INTERP_ADDR_CTRL, 1);
		repeat (200)
		begin
			repeat ($urandom % 4) @(posedge sys_clk);
			push_symbol($urandom, $urandom);
		end
		wait_drain();
		wait_outputs(10);
		halt_run();
		end_test("random stream");

		// fill while halted and hold two more on in_ready
		for (int k = 0; k < 8; k++)
			push_symbol($urandom, $urandom);
		@(posedge sys_clk);
		check_value("in_ready", 0, int'(in_ready));
		reg_read(`INTERP_ADDR_STATUS, rd);
		check_value("fifo_level", 8, int'(rd[19:16]));
		fork
			begin
				push_symbol($urandom, $urandom);
				push_symbol($urandom, $urandom);
			end
			reg_write(`INTERP_ADDR_CTRL, 1);
		join
		wait_drain();
		halt_run();
		reg_read(`INTERP_ADDR_STATUS, rd);
		check_value("fifo_level", 0, int'(rd[19:16]));
		end_test("back-pressure");

		// clear the counter then starve the FIFO
		reg_write(`INTERP_ADDR_CTRL, 2);
		uf_model = 0;
		for (int k = 0; k < 3; k++)
			push_symbol($urandom, $urandom);
		reg_write(`INTERP_ADDR_CTRL, 1);
		wait_outputs(24);
		halt_run();
		check_value("out_data.i", 0, int'(out_data.i));
		check_value("out_data.q", 0, int'(out_data.q));
		reg_read(`INTERP_ADDR_STATUS, rd);
		check_value("underflow_count", uf_model, int'(rd[15:0]));
		reg_write(`INTERP_ADDR_CTRL, 2);
		reg_read(`INTERP_ADDR_STATUS, rd);
		check_value("underflow_count", 0, int'(rd[15:0]));
		end_test("underflow");

		for (int k = 0; k < 4; k++)
			push_symbol($urandom, $urandom);
		reg_write(`INTERP_ADDR_CTRL, 1);
		wait_outputs(6);
		halt_run();
		end_test("halt");

		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- src.f
+incdir+logic
logic/interp_pkg.sv
logic/clk_en_gen.sv
logic/symbol_fifo.sv
logic/upsample_fir.sv
logic/interp_apb_regs.sv
logic/interp_top.sv
tb/interp_tb.sv
